// ==== list.f ====
+incdir+testbench
logic/placement_pkg.sv
logic/strip_finder.sv
logic/occupancy_array.sv
logic/fit_check.sv
logic/placement_ctrl.sv
logic/index_calc.sv
logic/placement_top.sv
testbench/placement_tb.sv

// ==== testbench/placement_model.svh ====
////////////////////
// Sequential reference model of the placement engine
// Included inside the testbench module, tracks strip widths and the strike count
////////////////////

`ifndef PLACEMENT_MODEL_SVH
`define PLACEMENT_MODEL_SVH

// One expected output beat, tag is the cycle the item was accepted
typedef struct packed {
    logic [31:0] tag;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [3:0]  strike;
} expect_t;

int model_occ [1:placement_pkg::NUM_STRIPS];
int model_strikes;

function automatic void model_reset();
    for (int s = 1; s <= placement_pkg::NUM_STRIPS; s++) begin
        model_occ[s] = 0;
    end
    model_strikes = 0;
endfunction

// Classes stack upward, class c has three strips of height 4*(c+1)
function automatic int class_base_y(input int cls);
    int y;
    y = 0;
    for (int i = 0; i < cls; i++) begin
        y += 3 * 4 * (i + 1);
    end
    return y;
endfunction

function automatic expect_t model_place(input int w, input int h);
    expect_t r;
    int      cls;
    int      count;
    int      first;
    int      best;
    int      best_occ;
    logic    struck;
    r      = '0;
    struck = 1'b1;
    if (w != 0 && h != 0) begin
        // Tallest class owns a single strip
        if (h > 16) begin
            cls   = 4;
            count = 1;
        end else begin
            cls   = (h - 1) / 4;
            count = 3;
        end
        first    = 3 * cls + 1;
        best     = first;
        best_occ = model_occ[first];
        for (int j = 1; j < count; j++) begin
            if (model_occ[first + j] < best_occ) begin
                best     = first + j;
                best_occ = model_occ[first + j];
            end
        end
        if (best_occ + w <= CANVAS_WIDTH) begin
            struck          = 1'b0;
            r.x             = 8'(best_occ);
            r.y             = 8'(class_base_y(cls) + (best - first) * 4 * (cls + 1));
            model_occ[best] = best_occ + w;
        end
    end
    if (struck) begin
        model_strikes = (model_strikes + 1) % 16;
    end
    r.strike = 4'(model_strikes);
    return r;
endfunction

`endif

// ==== testbench/placement_tb.sv ====
////////////////////
// Testbench for the placement engine
// Directed openings, then LFSR random items checked against a sequential model
////////////////////

`timescale 1ns/100ps

module placement_tb;

    localparam int CANVAS_WIDTH    = 128;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 34;
    localparam int RANDOM_CYCLES   = 600;
    localparam int DRAIN_CYCLES    = 4;
    localparam int MARGIN_CYCLES   = 46;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + DRAIN_CYCLES + MARGIN_CYCLES;

    logic                       clk_i;
    logic                       rst_i;
    logic                       valid_i;
    placement_pkg::dim_t        width_i;
    placement_pkg::dim_t        height_i;
    logic                       valid_o;
    placement_pkg::coord_t      index_x_o;
    placement_pkg::coord_t      index_y_o;
    placement_pkg::strike_cnt_t strike_o;

    int unsigned cycle_cnt   = 0;
    logic [15:0] lfsr_state  = 16'd44170;
    logic [3:0]  last_strike = '0;

    `include "placement_model.svh"

    expect_t exp_q [$];

    placement_top #(
        .CANVAS_WIDTH (CANVAS_WIDTH)
    ) dut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .valid_i   (valid_i),
        .width_i   (width_i),
        .height_i  (height_i),
        .valid_o   (valid_o),
        .index_x_o (index_x_o),
        .index_y_o (index_y_o),
        .strike_o  (strike_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////
    // Helpers

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    // Fibonacci LFSR with taps 16 14 13 11 and one step per bit handed out
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits       = {bits[14:0], fb};
        end
        return bits;
    endfunction

    task automatic drive_item(input logic v, input logic [4:0] w, input logic [4:0] h,
                              output expect_t exp);
        @(posedge clk_i);
        valid_i  <= v;
        width_i  <= w;
        height_i <= h;
        exp = '0;
        if (v) begin
            exp     = model_place(w, h);
            // Sampled by the DUT at the next edge
            exp.tag = cycle_cnt + 2;
            exp_q.push_back(exp);
        end
    endtask

    task automatic drive_idle(input int n);
        expect_t exp;
        for (int i = 0; i < n; i++) begin
            drive_item(1'b0, 5'd0, 5'd0, exp);
        end
    endtask

    task automatic place_directed(input int w, input int h, input int exp_x, input int exp_y);
        expect_t exp;
        drive_item(1'b1, 5'(w), 5'(h), exp);
        compare_value("model index_x_o", exp.x, exp_x);
        compare_value("model index_y_o", exp.y, exp_y);
    endtask

    task automatic run_random(input int n);
        expect_t     exp;
        logic        v;
        logic [4:0]  w;
        logic [4:0]  h;
        for (int i = 0; i < n; i++) begin
            v = (take_bits(2) != 16'd0);
            w = 5'(take_bits(5));
            h = 5'(take_bits(5));
            drive_item(v, w, h, exp);
        end
    endtask

    ////////////////////
    // Cycle counter and timeout

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout, run did not finish within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    ////////////////////
    // Output checker

    // Outputs are read on the falling edge while they are stable
    always @(negedge clk_i) begin : check_outputs
        expect_t exp;
        if (cycle_cnt >= 1) begin
            if (exp_q.size() != 0 && exp_q[0].tag + 2 == cycle_cnt) begin
                exp = exp_q.pop_front();
                compare_value("valid_o", valid_o, 1);
                compare_value("index_x_o", index_x_o, exp.x);
                compare_value("index_y_o", index_y_o, exp.y);
                compare_value("strike_o", strike_o, exp.strike);
                last_strike = exp.strike;
            end else begin
                // Idle beat where the count holds from the last item
                compare_value("valid_o", valid_o, 0);
                compare_value("index_x_o", index_x_o, 0);
                compare_value("index_y_o", index_y_o, 0);
                compare_value("strike_o", strike_o, last_strike);
            end
        end
    end

    ////////////////////
    // Stimulus

    initial begin : stimulus
        rst_i    = 1'b1;
        valid_i  = 1'b0;
        width_i  = '0;
        height_i = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        // Tie rule walks strips 1, 2, 3 then back to 1
        place_directed(10, 3, 0, 0);
        place_directed(10, 3, 0, 4);
        place_directed(10, 3, 0, 8);
        place_directed(10, 3, 10, 0);
        drive_idle(2);

        // Tallest strip fills after four items and the fifth overflows
        place_directed(31, 20, 0, 120);
        place_directed(31, 20, 31, 120);
        place_directed(31, 20, 62, 120);
        place_directed(31, 20, 93, 120);
        place_directed(31, 20, 0, 0);
        place_directed(5, 0, 0, 0);
        place_directed(0, 5, 0, 0);
        drive_idle(2);

        // Back to back strikes carry the counter through 15 to 0
        for (int i = 0; i < 17; i++) begin
            place_directed(1, 0, 0, 0);
        end
        drive_idle(2);

        run_random(RANDOM_CYCLES);
        drive_idle(DRAIN_CYCLES);

        if (exp_q.size() != 0) begin
            stop_with_failure($sformatf("No output seen for %0d accepted items",
                                        exp_q.size()));
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== logic/placement_top.sv ====
////////////////////
// Rectangle placement engine, top level
// Accepts one item per cycle when valid_i is high, results follow two edges later
////////////////////

`timescale 1ns/100ps

module placement_top #(
    parameter int CANVAS_WIDTH = 128
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       valid_i,
    input  placement_pkg::dim_t        width_i,
    input  placement_pkg::dim_t        height_i,

    output logic                       valid_o,
    output placement_pkg::coord_t      index_x_o,
    output placement_pkg::coord_t      index_y_o,
    output placement_pkg::strike_cnt_t strike_o
);

    // Input stage to update stage
    placement_pkg::cand_t        cand;

    // Update stage
    placement_pkg::coord_t [2:0] occ_width;
    placement_pkg::strip_id_t    sel_id;
    placement_pkg::coord_t       sel_width;
    placement_pkg::coord_t       new_width;
    logic                        strike;
    logic                        wr_en;
    placement_pkg::strip_id_t    wr_id;
    placement_pkg::coord_t       wr_width;

    // Update stage to output stage
    placement_pkg::place_t       place;

    ////////////////////
    // Input sampling and row search

    strip_finder u_finder (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (valid_i),
        .width_i  (width_i),
        .height_i (height_i),
        .cand_o   (cand)
    );

    ////////////////////
    // Update stage

    occupancy_array #(
        .CANVAS_WIDTH (CANVAS_WIDTH)
    ) u_occupancy (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_id_i    (cand.ids),
        .wr_en_i    (wr_en),
        .wr_id_i    (wr_id),
        .wr_width_i (wr_width),
        .rd_width_o (occ_width)
    );

    fit_check #(
        .CANVAS_WIDTH (CANVAS_WIDTH)
    ) u_fit (
        .cand_i      (cand),
        .occ_i       (occ_width),
        .sel_id_o    (sel_id),
        .sel_width_o (sel_width),
        .new_width_o (new_width),
        .strike_o    (strike)
    );

    placement_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cand_valid_i (cand.valid),
        .sel_id_i     (sel_id),
        .sel_width_i  (sel_width),
        .new_width_i  (new_width),
        .strike_i     (strike),
        .wr_en_o      (wr_en),
        .wr_id_o      (wr_id),
        .wr_width_o   (wr_width),
        .place_o      (place)
    );

    ////////////////////
    // Index calculation and output registers

    index_calc u_index (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .place_i   (place),
        .valid_o   (valid_o),
        .index_x_o (index_x_o),
        .index_y_o (index_y_o),
        .strike_o  (strike_o)
    );

endmodule

// ==== logic/index_calc.sv ====
////////////////////
// Output stage
// Turns a placement record into the registered x, y origin and strike count
////////////////////

`timescale 1ns/100ps

module index_calc (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  placement_pkg::place_t      place_i,

    output logic                       valid_o,
    output placement_pkg::coord_t      index_x_o,
    output placement_pkg::coord_t      index_y_o,
    output placement_pkg::strike_cnt_t strike_o
);

    logic                  placed;
    placement_pkg::coord_t x_d;
    placement_pkg::coord_t y_d;

    // Coordinates are zero on a strike and on idle cycles
    assign placed = place_i.valid && !place_i.strike;
    assign x_d    = placed ? place_i.x : '0;
    assign y_d    = placed ? placement_pkg::strip_base_y(place_i.strip) : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            index_x_o <= '0;
            index_y_o <= '0;
            strike_o  <= '0;
        end else begin
            valid_o   <= place_i.valid;
            index_x_o <= x_d;
            index_y_o <= y_d;
            // Count holds between items
            if (place_i.valid) begin
                strike_o <= place_i.strike_cnt;
            end
        end
    end

endmodule

// ==== logic/placement_ctrl.sv ====
////////////////////
// Control for the update stage
// Commits array writes, counts strikes and registers the placement record
////////////////////

`timescale 1ns/100ps

module placement_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     cand_valid_i,
    input  placement_pkg::strip_id_t sel_id_i,
    input  placement_pkg::coord_t    sel_width_i,
    input  placement_pkg::coord_t    new_width_i,
    input  logic                     strike_i,

    output logic                     wr_en_o,
    output placement_pkg::strip_id_t wr_id_o,
    output placement_pkg::coord_t    wr_width_o,
    output placement_pkg::place_t    place_o
);

    placement_pkg::strike_cnt_t strike_cnt_q;
    placement_pkg::strike_cnt_t strike_cnt_d;
    placement_pkg::place_t      place_q;

    logic valid_strike;

    ////////////////////
    // Array write

    // Written at the same edge that registers the result, so the next
    // item already reads the new width
    assign wr_en_o    = cand_valid_i && !strike_i;
    assign wr_id_o    = sel_id_i;
    assign wr_width_o = new_width_i;

    ////////////////////
    // Strike counter

    assign valid_strike = cand_valid_i && strike_i;

    // Wraps after 15
    assign strike_cnt_d = valid_strike ? strike_cnt_q + 4'd1 : strike_cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            strike_cnt_q <= '0;
        end else begin
            strike_cnt_q <= strike_cnt_d;
        end
    end

    ////////////////////
    // Result register

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            place_q.valid <= 1'b0;
        end else begin
            place_q.valid <= cand_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        place_q.strike     <= strike_i;
        place_q.strip      <= sel_id_i;
        place_q.x          <= sel_width_i;
        place_q.strike_cnt <= strike_cnt_d;
    end

    assign place_o = place_q;

endmodule

// ==== logic/fit_check.sv ====
////////////////////
// Picks the least occupied candidate strip and tests whether the item fits
// Purely combinational, part of the single update stage
////////////////////

`timescale 1ns/100ps

module fit_check #(
    parameter int CANVAS_WIDTH = 128
) (
    input  placement_pkg::cand_t        cand_i,
    input  placement_pkg::coord_t [2:0] occ_i,

    output placement_pkg::strip_id_t    sel_id_o,
    output placement_pkg::coord_t       sel_width_o,
    output placement_pkg::coord_t       new_width_o,
    output logic                        strike_o
);

    logic [1:0] best;
    logic [8:0] sum;

    ////////////////////
    // Minimum width selection

    // Strict compare keeps the earlier candidate on a tie
    always_comb begin
        best = 2'd0;
        if (occ_i[1] < occ_i[best]) begin
            best = 2'd1;
        end
        if (occ_i[2] < occ_i[best]) begin
            best = 2'd2;
        end
    end

    assign sel_id_o    = cand_i.ids[best];
    assign sel_width_o = occ_i[best];

    ////////////////////
    // Strike detection

    assign sum = {1'b0, sel_width_o} + {4'd0, cand_i.width};

    always_comb begin
        strike_o = (sel_id_o == placement_pkg::NO_STRIP) || (sum > CANVAS_WIDTH);
        if (strike_o) begin
            // Strip keeps its width
            new_width_o = sel_width_o;
        end else begin
            new_width_o = sum[7:0];
        end
    end

endmodule

// ==== logic/occupancy_array.sv ====
////////////////////
// Occupied width of each real strip
// Three combinational read ports and one write port, NO_STRIP reads as a full strip
////////////////////

`timescale 1ns/100ps

module occupancy_array #(
    parameter int CANVAS_WIDTH = 128
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  placement_pkg::strip_set_t rd_id_i,
    input  logic                      wr_en_i,
    input  placement_pkg::strip_id_t  wr_id_i,
    input  placement_pkg::coord_t     wr_width_i,

    output placement_pkg::coord_t [2:0] rd_width_o
);

    localparam placement_pkg::coord_t FULL_WIDTH = placement_pkg::coord_t'(CANVAS_WIDTH);

    // Strip 0 is not stored
    placement_pkg::coord_t occ_q [1:placement_pkg::NUM_STRIPS];

    logic wr_ok;

    assign wr_ok = wr_en_i && (wr_id_i != placement_pkg::NO_STRIP)
                   && (wr_id_i <= placement_pkg::NUM_STRIPS);

    ////////////////////
    // Write port

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 1; s <= placement_pkg::NUM_STRIPS; s++) begin
                occ_q[s] <= '0;
            end
        end else if (wr_ok) begin
            occ_q[wr_id_i] <= wr_width_i;
        end
    end

    ////////////////////
    // Read ports

    // Unused ids look full so they never win the selection
    always_comb begin
        for (int p = 0; p < 3; p++) begin
            if (rd_id_i[p] == placement_pkg::NO_STRIP
                    || rd_id_i[p] > placement_pkg::NUM_STRIPS) begin
                rd_width_o[p] = FULL_WIDTH;
            end else begin
                rd_width_o[p] = occ_q[rd_id_i[p]];
            end
        end
    end

endmodule

// ==== logic/strip_finder.sv ====
////////////////////
// Input stage of the placement pipeline
// Samples an item and registers its three candidate strips
////////////////////

`timescale 1ns/100ps

module strip_finder (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  placement_pkg::dim_t width_i,
    input  placement_pkg::dim_t height_i,

    output placement_pkg::cand_t cand_o
);

    placement_pkg::cand_t cand_d;
    placement_pkg::cand_t cand_q;

    ////////////////////
    // Row search

    always_comb begin
        cand_d.valid = valid_i;
        cand_d.width = width_i;
        cand_d.ids   = placement_pkg::strip_candidates(height_i, width_i);
    end

    ////////////////////
    // Candidate register

    // Valid bit of the sampled item
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cand_q.valid <= 1'b0;
        end else begin
            cand_q.valid <= cand_d.valid;
        end
    end

    // Item width and candidate strips
    always_ff @(posedge clk_i) begin
        cand_q.width <= cand_d.width;
        cand_q.ids   <= cand_d.ids;
    end

    assign cand_o = cand_q;

endmodule

// ==== logic/placement_pkg.sv ====
////////////////////
// Shared types, constants and strip lookups for the rectangle placement engine
// Modules reference everything here by scoped name
////////////////////

package placement_pkg;

    // Scalar types
    typedef logic [4:0] dim_t;
    typedef logic [3:0] strip_id_t;
    typedef logic [7:0] coord_t;
    typedef logic [3:0] strike_cnt_t;

    // Three candidate strips, index 0 is the first preference
    typedef strip_id_t [2:0] strip_set_t;

    localparam int        NUM_STRIPS = 13;
    localparam strip_id_t NO_STRIP   = 4'd0;

    // Item entering the update stage
    typedef struct packed {
        logic       valid;
        dim_t       width;
        strip_set_t ids;
    } cand_t;

    // Result of the update stage, consumed by the output stage
    typedef struct packed {
        logic        valid;
        logic        strike;
        strip_id_t   strip;
        coord_t      x;
        strike_cnt_t strike_cnt;
    } place_t;

    // Height class picks three consecutive strips, tallest class has only one
    function automatic strip_set_t strip_candidates(input dim_t height, input dim_t width);
        strip_set_t ids;
        strip_id_t  first;
        ids   = {NO_STRIP, NO_STRIP, NO_STRIP};
        first = NO_STRIP;
        if (height != '0 && width != '0) begin
            if (height <= 5'd4) begin
                first = 4'd1;
            end else if (height <= 5'd8) begin
                first = 4'd4;
            end else if (height <= 5'd12) begin
                first = 4'd7;
            end else if (height <= 5'd16) begin
                first = 4'd10;
            end else begin
                ids[0] = 4'd13;
            end
            if (first != NO_STRIP) begin
                ids[0] = first;
                ids[1] = first + 4'd1;
                ids[2] = first + 4'd2;
            end
        end
        return ids;
    endfunction

    // Bottom edge of each strip on the canvas
    function automatic coord_t strip_base_y(input strip_id_t id);
        case (id)
            4'd1:    return 8'd0;
            4'd2:    return 8'd4;
            4'd3:    return 8'd8;
            4'd4:    return 8'd12;
            4'd5:    return 8'd20;
            4'd6:    return 8'd28;
            4'd7:    return 8'd36;
            4'd8:    return 8'd48;
            4'd9:    return 8'd60;
            4'd10:   return 8'd72;
            4'd11:   return 8'd88;
            4'd12:   return 8'd104;
            4'd13:   return 8'd120;
            default: return 8'd0;
        endcase
    endfunction

endpackage
